//--- sources.f
source/per_ctrl_pkg.sv
source/per_clk_en_vote.sv
source/per_rst_seq.sv
source/per_clk_gate.sv
source/per_clk_rst_top.sv
tb/tb_clk_gen.sv
tb/per_clk_rst_chk.sv
tb/tb_per_clk_rst.sv

//--- Makefile
# Verilator build and run of the peripheral clock and reset testbench
# any variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_per_clk_rst
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_per_clk_rst.sv
// directed testbench for the peripheral clock and reset controller
// reference vote and reset functions over the package tables
// per_clk pulse counting, lcg stimulus, timeout and result report

`timescale 1ns/1ns
`default_nettype none

module tb_per_clk_rst
  import per_ctrl_pkg::*;
();

  localparam int SETTLE_CYCLES = 2;
  localparam int WIN_CYCLES = 8;
  localparam int WIN_LEN = SETTLE_CYCLES + WIN_CYCLES;
  // falling edges watched after a reset release
  localparam int REL_LEN = 2 + CLK_ON_DELAY + 2;
  localparam int NUM_VOTES = 20;
  // release, vote, d3, resets, testmode
  localparam int TEST_CYCLES = 20 + NUM_VOTES * WIN_LEN + 4 * WIN_LEN
                               + (2 + NUM_PER) * (WIN_LEN + REL_LEN) + 2 * WIN_LEN;
  localparam int MAX_CYCLES = 3 * TEST_CYCLES;

  logic               bus_clk;
  logic               arst_n;
  logic [NUM_PER-1:0] c1_per_en;
  logic [NUM_PER-1:0] c1_per_lpen;
  logic [NUM_PER-1:0] c2_per_en;
  logic [NUM_PER-1:0] c2_per_lpen;
  logic [NUM_PER-1:0] per_amen;
  logic               c1_sleep;
  logic               c1_deepsleep;
  logic               c2_sleep;
  logic               c2_deepsleep;
  logic               d3_deepsleep;
  logic               d1_rst_n;
  logic               d2_rst_n;
  logic [NUM_PER-1:0] sft_rst_n;
  logic               arcg_on;
  logic               testmode;
  logic [NUM_PER-1:0] per_clk;
  logic [NUM_PER-1:0] per_rst_n;

  int                 pulse_cnt [NUM_PER] = '{default: 0};
  int                 win_cnt [NUM_PER];
  logic [NUM_PER-1:0] clk_q = '0;
  logic [31:0]        lcg_state = 32'd26;
  int                 cycles = 0;
  int                 err_cnt = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;
  logic               run_done = 1'b0;

  tb_clk_gen i_clk_gen (.*);

  // port names match the testbench signals one to one
  per_clk_rst_top i_dut (.*);

  bind per_clk_rst_top per_clk_rst_chk i_chk (
    .bus_clk   (bus_clk),
    .arst_n    (arst_n),
    .vote_en   (vote_en),
    .arcg_en   (arcg_en),
    .per_rst_n (per_rst_n),
    .testmode  (testmode),
    .per_clk   (per_clk)
  );

  // ==========================================================================
  // pulse counters and timeout
  // ==========================================================================

  // rising edges of every gated clock
  always @(per_clk) begin
    for (int p = 0; p < NUM_PER; p++) begin
      if (per_clk[p] && !clk_q[p]) begin
        pulse_cnt[p] = pulse_cnt[p] + 1;
      end
    end
    clk_q = per_clk;
  end

  always @(posedge bus_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: tests still running after %0d bus_clk cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      run_done = 1'b1;
      $finish;
    end
  end

  // run ended before the closing report
  final begin
    if (!run_done) begin
      $display("SIMULATION FAILED");
    end
  end

  // ==========================================================================
  // reference model and helpers
  // ==========================================================================

  function automatic logic [NUM_PER-1:0] ref_vote_vec();
    logic [NUM_PER-1:0] v;
    logic c1_t;
    logic c2_t;
    logic d3_t;
    for (int p = 0; p < NUM_PER; p++) begin
      c1_t = (c1_per_en[p] || PER_CPU1_ASSIGNED[p]) && !c1_deepsleep
             && (!c1_sleep || !PER_LPEN_SUPPORT[p] || c1_per_lpen[p]);
      c2_t = (c2_per_en[p] || PER_CPU2_ASSIGNED[p]) && !c2_deepsleep
             && (!c2_sleep || !PER_LPEN_SUPPORT[p] || c2_per_lpen[p]);
      if (PER_DOMAIN[p] != DOM_D3) begin
        d3_t = 1'b0;
      end else if (PER_AMEN_SUPPORT[p]) begin
        d3_t = per_amen[p] && !d3_deepsleep;
      end else begin
        d3_t = !PER_D3_NO_CLK[p] && !d3_deepsleep;
      end
      v[p] = c1_t || c2_t || d3_t;
    end
    return v;
  endfunction

  // high bit means the peripheral is out of reset
  function automatic logic [NUM_PER-1:0] ref_rst_vec();
    logic [NUM_PER-1:0] v;
    logic dom_ok;
    for (int p = 0; p < NUM_PER; p++) begin
      case (PER_DOMAIN[p])
        DOM_D1:  dom_ok = d1_rst_n;
        DOM_D2:  dom_ok = d2_rst_n;
        default: dom_ok = 1'b1;
      endcase
      v[p] = arst_n && dom_ok && sft_rst_n[p];
    end
    return v;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic set_defaults();
    c1_per_en    = '1;
    c1_per_lpen  = '0;
    c2_per_en    = '0;
    c2_per_lpen  = '0;
    per_amen     = '1;
    c1_sleep     = 1'b0;
    c1_deepsleep = 1'b0;
    c2_sleep     = 1'b0;
    c2_deepsleep = 1'b0;
    d3_deepsleep = 1'b0;
    d1_rst_n     = 1'b1;
    d2_rst_n     = 1'b1;
    sft_rst_n    = '1;
    arcg_on      = 1'b1;
    testmode     = 1'b0;
  endtask

  task automatic note_mismatch(input string what, input int got, input int exp);
    err_cnt++;
    $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
  endtask

  task automatic close_test(input string name, input int err_before);
    tests_run++;
    if (err_cnt == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_cnt - err_before);
    end
  endtask

  // settle, then count pulses between falling edges
  task automatic check_window(input logic [NUM_PER-1:0] mask,
                              input logic [NUM_PER-1:0] run, input string tag);
    int base [NUM_PER];
    int exp;
    repeat (SETTLE_CYCLES) @(negedge bus_clk);
    base = pulse_cnt;
    repeat (WIN_CYCLES) @(negedge bus_clk);
    for (int p = 0; p < NUM_PER; p++) begin
      win_cnt[p] = pulse_cnt[p] - base[p];
      exp = run[p] ? WIN_CYCLES : 0;
      if (mask[p] && win_cnt[p] != exp) begin
        note_mismatch($sformatf("%s per_clk[%0d] pulses", tag, p), win_cnt[p], exp);
      end
    end
  endtask

  // called on the falling edge that releases the raw reset
  task automatic check_release(input logic [NUM_PER-1:0] mask, input int dly,
                               input string tag);
    int base [NUM_PER];
    int exp;
    base = pulse_cnt;
    for (int k = 1; k <= REL_LEN; k++) begin
      @(negedge bus_clk);
      // two synchronizer edges, then the clock-on delay, then the first pulse
      exp = (k > 2 + dly) ? k - 2 - dly : 0;
      for (int p = 0; p < NUM_PER; p++) begin
        if (mask[p] && per_rst_n[p] != (k >= 2)) begin
          note_mismatch($sformatf("%s per_rst_n[%0d] edge %0d", tag, p, k),
                        int'(per_rst_n[p]), int'(k >= 2));
        end
        if (mask[p] && pulse_cnt[p] - base[p] != exp) begin
          note_mismatch($sformatf("%s per_clk[%0d] edge %0d", tag, p, k),
                        pulse_cnt[p] - base[p], exp);
        end
      end
    end
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================

  task automatic test_reset_release();
    int err0;
    err0 = err_cnt;
    repeat (8) begin
      @(posedge bus_clk);
      if (per_rst_n != '0) begin
        note_mismatch("per_rst_n under arst_n", int'(per_rst_n), 0);
      end
    end
    @(posedge arst_n);
    check_release('1, CLK_ON_DELAY, "arst_n release");
    close_test("reset release", err0);
  endtask

  task automatic test_cpu_vote();
    int err0;
    logic [31:0] r;
    err0 = err_cnt;
    for (int i = 0; i < NUM_VOTES; i++) begin
      r = lcg_next();
      c1_per_en[1:0]   = r[17:16];
      c1_per_lpen[1:0] = r[19:18];
      c2_per_en[1:0]   = r[21:20];
      c2_per_lpen[1:0] = r[23:22];
      c1_sleep         = r[24];
      c2_sleep         = r[25];
      // deepsleep about a quarter of the time
      c1_deepsleep     = r[26] & r[27];
      c2_deepsleep     = r[28] & r[29];
      check_window(4'b0011, ref_vote_vec(), $sformatf("vote %0d", i));
    end
    set_defaults();
    close_test("cpu voting", err0);
  endtask

  task automatic test_d3_path();
    int err0;
    err0 = err_cnt;
    // only the d3 path left for 2 and 3
    c1_per_en = '0;
    for (int i = 0; i < 4; i++) begin
      per_amen[2]  = i[0];
      d3_deepsleep = i[1];
      check_window(4'b1100, ref_vote_vec(), $sformatf("d3 case %0d", i));
    end
    set_defaults();
    close_test("d3 path", err0);
  endtask

  task automatic test_resets();
    int err0;
    logic [NUM_PER-1:0] exp_rst;
    err0 = err_cnt;
    for (int c = 0; c < 2 + NUM_PER; c++) begin
      // d1, then d2, then each software reset bit
      if (c == 0) begin
        d1_rst_n = 1'b0;
      end else if (c == 1) begin
        d2_rst_n = 1'b0;
      end else begin
        sft_rst_n[c-2] = 1'b0;
      end
      exp_rst = ref_rst_vec();
      check_window('1, exp_rst & ref_vote_vec(), $sformatf("reset case %0d", c));
      if (per_rst_n != exp_rst) begin
        note_mismatch($sformatf("reset case %0d per_rst_n", c),
                      int'(per_rst_n), int'(exp_rst));
      end
      d1_rst_n  = 1'b1;
      d2_rst_n  = 1'b1;
      sft_rst_n = '1;
      // even cases release without the clock-on delay
      arcg_on   = c[0];
      check_release(~exp_rst, arcg_on ? CLK_ON_DELAY : 0,
                    $sformatf("reset case %0d release", c));
    end
    arcg_on = 1'b1;
    close_test("domain and software resets", err0);
  endtask

  task automatic test_testmode();
    int err0;
    err0 = err_cnt;
    c1_per_en    = '0;
    c1_per_lpen  = '0;
    c2_per_en    = '0;
    c2_per_lpen  = '0;
    per_amen     = '0;
    d3_deepsleep = 1'b1;
    sft_rst_n    = '0;
    testmode     = 1'b1;
    check_window('1, '1, "testmode");
    if (per_rst_n != '0) begin
      note_mismatch("testmode per_rst_n", int'(per_rst_n), 0);
    end
    // bypass off, resets still active
    testmode = 1'b0;
    check_window('1, '0, "testmode off");
    set_defaults();
    close_test("testmode bypass", err0);
  endtask

  // ==========================================================================
  // sequence and report
  // ==========================================================================

  initial begin
    set_defaults();
    test_reset_release();
    test_cpu_vote();
    test_d3_path();
    test_resets();
    test_testmode();
    $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, err_cnt, i_dut.i_chk.fail_cnt);
    run_done = 1'b1;
    if (err_cnt == 0 && i_dut.i_chk.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/per_clk_rst_chk.sv
// bound checker for the peripheral clock and reset controller
// reset held under arst_n, no clock in reset, stable gate enable

`timescale 1ns/1ns
`default_nettype none

module per_clk_rst_chk
  import per_ctrl_pkg::*;
(
  input wire logic               bus_clk,
  input wire logic               arst_n,
  input wire logic [NUM_PER-1:0] vote_en,
  input wire logic [NUM_PER-1:0] arcg_en,
  input wire logic [NUM_PER-1:0] per_rst_n,
  input wire logic               testmode,
  input wire logic [NUM_PER-1:0] per_clk
);

  logic [NUM_PER-1:0] gate_en;
  logic [NUM_PER-1:0] en_at_rise = '0;
  // assertion failure count
  int                 fail_cnt = 0;

  // gate enable as seen in front of the latch
  assign gate_en = (vote_en & arcg_en & per_rst_n) | {NUM_PER{testmode}};

  // value the latch closes on at the rising edge
  always @(posedge bus_clk) begin
    en_at_rise <= gate_en;
  end

  // ==========================================================================
  // assertions
  // ==========================================================================

  a_rst_in_arst: assert property (@(posedge bus_clk) !arst_n |-> per_rst_n == '0)
    else begin
      fail_cnt++;
      $error("per_rst_n not all low while arst_n is low");
    end

  // sampled at the falling edge, so per_clk is the high-phase value
  a_no_clk_in_rst: assert property (
    @(negedge bus_clk) (per_clk & ~per_rst_n & {NUM_PER{~testmode}}) == '0)
    else begin
      fail_cnt++;
      $error("per_clk pulse while per_rst_n low and testmode clear");
    end

  a_gate_stable: assert property (@(negedge bus_clk) per_clk == en_at_rise)
    else begin
      fail_cnt++;
      $error("per_clk high phase differs from the enable latched at the rise");
    end

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
// bus clock source for the testbench, 10 ns period
// power-on reset held low for the first 10 cycles

`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic bus_clk,
  output logic arst_n
);

  initial begin
    bus_clk = 1'b0;
    forever #5 bus_clk = ~bus_clk;
  end

  // release on a falling edge, like every other input
  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge bus_clk);
    @(negedge bus_clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- source/per_clk_rst_top.sv
// peripheral clock and reset controller top level
// enable vote and reset sequencer side by side
// clock gate combining both results

`timescale 1ns/1ns
`default_nettype none

module per_clk_rst_top
  import per_ctrl_pkg::*;
(
  input  wire logic               bus_clk,
  input  wire logic               arst_n,
  // cpu and autonomous enables
  input  wire logic [NUM_PER-1:0] c1_per_en,
  input  wire logic [NUM_PER-1:0] c1_per_lpen,
  input  wire logic [NUM_PER-1:0] c2_per_en,
  input  wire logic [NUM_PER-1:0] c2_per_lpen,
  input  wire logic [NUM_PER-1:0] per_amen,
  // low-power states
  input  wire logic               c1_sleep,
  input  wire logic               c1_deepsleep,
  input  wire logic               c2_sleep,
  input  wire logic               c2_deepsleep,
  input  wire logic               d3_deepsleep,
  // domain and software resets
  input  wire logic               d1_rst_n,
  input  wire logic               d2_rst_n,
  input  wire logic [NUM_PER-1:0] sft_rst_n,
  input  wire logic               arcg_on,
  input  wire logic               testmode,
  output logic      [NUM_PER-1:0] per_clk,
  output logic      [NUM_PER-1:0] per_rst_n
);

  logic [NUM_PER-1:0] vote_en;
  logic [NUM_PER-1:0] arcg_en;

  // ==========================================================================
  // enable vote
  // ==========================================================================

  per_clk_en_vote i_vote (
    .c1_per_en    (c1_per_en),
    .c1_per_lpen  (c1_per_lpen),
    .c2_per_en    (c2_per_en),
    .c2_per_lpen  (c2_per_lpen),
    .per_amen     (per_amen),
    .c1_sleep     (c1_sleep),
    .c1_deepsleep (c1_deepsleep),
    .c2_sleep     (c2_sleep),
    .c2_deepsleep (c2_deepsleep),
    .d3_deepsleep (d3_deepsleep),
    .vote_en      (vote_en)
  );

  // ==========================================================================
  // reset sequencing and gating
  // ==========================================================================

  per_rst_seq i_rst_seq (
    .bus_clk   (bus_clk),
    .arst_n    (arst_n),
    .d1_rst_n  (d1_rst_n),
    .d2_rst_n  (d2_rst_n),
    .sft_rst_n (sft_rst_n),
    .arcg_on   (arcg_on),
    .per_rst_n (per_rst_n),
    .arcg_en   (arcg_en)
  );

  // one gated copy of bus_clk per peripheral
  per_clk_gate i_gate (
    .bus_clk   (bus_clk),
    .vote_en   (vote_en),
    .arcg_en   (arcg_en),
    .per_rst_n (per_rst_n),
    .testmode  (testmode),
    .per_clk   (per_clk)
  );

endmodule

`default_nettype wire

//--- source/per_clk_gate.sv
// latch based glitch-free bus clock gate per peripheral
// merges vote, delay enable and reset
// testmode bypass forces the clock through

`timescale 1ns/1ns
`default_nettype none

module per_clk_gate
  import per_ctrl_pkg::*;
(
  input  wire logic               bus_clk,
  input  wire logic [NUM_PER-1:0] vote_en,
  input  wire logic [NUM_PER-1:0] arcg_en,
  input  wire logic [NUM_PER-1:0] per_rst_n,
  input  wire logic               testmode,
  output logic      [NUM_PER-1:0] per_clk
);

  // ==========================================================================
  // enable merge and gating
  // ==========================================================================

  for (genvar g = 0; g < NUM_PER; g++) begin : g_gate
    logic en;
    logic en_lat;

    // all three must agree, or scan bypass
    assign en = (vote_en[g] & arcg_en[g] & per_rst_n[g]) | testmode;

    // transparent in the low phase
    always_latch begin
      if (!bus_clk) begin
        en_lat = en;
      end
    end

    // stable enable over the high phase
    assign per_clk[g] = bus_clk & en_lat;
  end

endmodule

`default_nettype wire

//--- source/per_rst_seq.sv
// per peripheral reset sequencer
// raw reset from arst_n, domain reset and software reset
// async assert, sync release two-flop synchronizer
// fsm delaying the clock enable after reset release

`timescale 1ns/1ns
`default_nettype none

module per_rst_seq
  import per_ctrl_pkg::*;
(
  input  wire logic               bus_clk,
  input  wire logic               arst_n,
  input  wire logic               d1_rst_n,
  input  wire logic               d2_rst_n,
  input  wire logic [NUM_PER-1:0] sft_rst_n,
  input  wire logic               arcg_on,
  output logic      [NUM_PER-1:0] per_rst_n,
  output logic      [NUM_PER-1:0] arcg_en
);

  for (genvar g = 0; g < NUM_PER; g++) begin : g_seq
    logic                 raw_rst_n;
    logic [1:0]           sync_q;
    rst_state_e           state;
    logic [DLY_CNT_W-1:0] cnt;

    // ========================================================================
    // raw reset per domain
    // ========================================================================

    if (PER_DOMAIN[g] == DOM_D1) begin : g_d1
      assign raw_rst_n = arst_n & d1_rst_n & sft_rst_n[g];
    end else if (PER_DOMAIN[g] == DOM_D2) begin : g_d2
      assign raw_rst_n = arst_n & d2_rst_n & sft_rst_n[g];
    end else begin : g_d3
      // d3 has no domain reset of its own
      assign raw_rst_n = arst_n & sft_rst_n[g];
    end

    // ========================================================================
    // synchronizer
    // ========================================================================

    // falls at once, rises on second edge after release
    always_ff @(posedge bus_clk or negedge raw_rst_n) begin
      if (!raw_rst_n) begin
        sync_q <= 2'b00;
      end else begin
        sync_q <= {sync_q[0], 1'b1};
      end
    end

    assign per_rst_n[g] = sync_q[1];

    // ========================================================================
    // clock-on delay fsm
    // ========================================================================

    // held in RST_HELD by the synchronized reset
    always_ff @(posedge bus_clk or negedge sync_q[1]) begin
      if (!sync_q[1]) begin
        state <= RST_HELD;
        cnt   <= '0;
      end else begin
        case (state)
          RST_HELD: begin
            // first edge after release already counts
            if (arcg_on && CLK_ON_DELAY > 1) begin
              state <= RST_WAIT;
              cnt   <= DLY_CNT_W'(1);
            end else begin
              state <= RST_RUN;
            end
          end
          RST_WAIT: begin
            if (cnt == DLY_CNT_W'(CLK_ON_DELAY - 1)) begin
              state <= RST_RUN;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
          default: begin
            state <= RST_RUN;
          end
        endcase
      end
    end

    // no delay wanted, follow the reset directly
    assign arcg_en[g] = (arcg_on && CLK_ON_DELAY > 0) ? (state == RST_RUN) : sync_q[1];
  end

endmodule

`default_nettype wire

//--- source/per_clk_en_vote.sv
// combinational bus clock enable vote per peripheral
// cpu1 and cpu2 run/sleep terms with optional lpen
// d3 autonomous path with optional amen
// all options come from the package tables

`timescale 1ns/1ns
`default_nettype none

module per_clk_en_vote
  import per_ctrl_pkg::*;
(
  input  wire logic [NUM_PER-1:0] c1_per_en,
  input  wire logic [NUM_PER-1:0] c1_per_lpen,
  input  wire logic [NUM_PER-1:0] c2_per_en,
  input  wire logic [NUM_PER-1:0] c2_per_lpen,
  input  wire logic [NUM_PER-1:0] per_amen,
  input  wire logic               c1_sleep,
  input  wire logic               c1_deepsleep,
  input  wire logic               c2_sleep,
  input  wire logic               c2_deepsleep,
  input  wire logic               d3_deepsleep,
  output logic      [NUM_PER-1:0] vote_en
);

  // ==========================================================================
  // per peripheral vote
  // ==========================================================================

  for (genvar g = 0; g < NUM_PER; g++) begin : g_vote
    logic c1_lp_ok;
    logic c2_lp_ok;
    logic c1_term;
    logic c2_term;
    logic d3_term;

    // low-power term, constant 1 without lpen support
    assign c1_lp_ok = ~c1_sleep | ~PER_LPEN_SUPPORT[g] | c1_per_lpen[g];
    assign c2_lp_ok = ~c2_sleep | ~PER_LPEN_SUPPORT[g] | c2_per_lpen[g];

    // assigned cpu forces its enable high
    assign c1_term = (c1_per_en[g] | PER_CPU1_ASSIGNED[g]) & c1_lp_ok & ~c1_deepsleep;
    assign c2_term = (c2_per_en[g] | PER_CPU2_ASSIGNED[g]) & c2_lp_ok & ~c2_deepsleep;

    // d3 stop-mode path
    if (PER_DOMAIN[g] != DOM_D3) begin : g_no_d3
      // d1 and d2 never clocked from d3
      assign d3_term = 1'b0;
    end else if (PER_AMEN_SUPPORT[g]) begin : g_d3_amen
      // autonomous mode until d3 enters deepsleep
      assign d3_term = per_amen[g] & ~d3_deepsleep;
    end else if (PER_D3_NO_CLK[g]) begin : g_d3_off
      assign d3_term = 1'b0;
    end else begin : g_d3_default
      // clock on by default while d3 awake
      assign d3_term = ~d3_deepsleep;
    end

    // any requester keeps the clock
    assign vote_en[g] = c1_term | c2_term | d3_term;
  end

endmodule

`default_nettype wire

//--- source/per_ctrl_pkg.sv
// peripheral clock and reset controller package
// peripheral count and clock-on delay after reset release
// power domain and reset sequencer state enums
// per-peripheral configuration tables for the whole group

`default_nettype none

package per_ctrl_pkg;

  // ==========================================================================
  // sizes and timing
  // ==========================================================================

  // number of controlled peripherals
  localparam int NUM_PER = 4;
  // bus_clk cycles from reset release to clock on, arcg_on set
  localparam int CLK_ON_DELAY = 2;
  // wide enough to hold CLK_ON_DELAY
  localparam int DLY_CNT_W = $clog2(CLK_ON_DELAY + 1);

  // ==========================================================================
  // enums
  // ==========================================================================

  typedef enum logic [1:0] {
    DOM_D1,
    DOM_D2,
    DOM_D3
  } per_domain_e;

  // reset sequencer, per peripheral
  typedef enum logic [1:0] {
    RST_HELD,
    RST_WAIT,
    RST_RUN
  } rst_state_e;

  // ==========================================================================
  // configuration tables, bit / entry n is peripheral n
  // ==========================================================================

  localparam per_domain_e PER_DOMAIN [NUM_PER] = '{DOM_D1, DOM_D2, DOM_D3, DOM_D3};

  // cpu enable implied true
  localparam logic [NUM_PER-1:0] PER_CPU1_ASSIGNED = 4'b0001;
  localparam logic [NUM_PER-1:0] PER_CPU2_ASSIGNED = 4'b0000;
  // lpen honoured while the cpu sleeps
  localparam logic [NUM_PER-1:0] PER_LPEN_SUPPORT = 4'b0011;
  // d3 only, autonomous enable present
  localparam logic [NUM_PER-1:0] PER_AMEN_SUPPORT = 4'b0100;
  // d3 only, no clock by default when amen absent
  localparam logic [NUM_PER-1:0] PER_D3_NO_CLK = 4'b0000;

endpackage

`default_nettype wire
